// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int word_width = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs = 32;

  // jal, jalr and the linking regimm branches write here
  localparam int link_register = 31;

  // field positions inside the instruction word
  localparam int opcode_lsb = 26;
  localparam int opcode_width = 6;
  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;
  localparam int shamt_lsb = 6;
  localparam int shamt_width = 5;
  localparam int funct_width = 6;
  localparam int jump_index_width = 26;

  typedef logic [word_width-1:0] word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  typedef enum logic [opcode_width-1:0] {
    op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
    op_beq     = 6'h04, op_bne    = 6'h05, op_blez  = 6'h06, op_bgtz  = 6'h07,
    op_addi    = 6'h08, op_addiu  = 6'h09, op_slti  = 6'h0a, op_sltiu = 6'h0b,
    op_andi    = 6'h0c, op_ori    = 6'h0d, op_xori  = 6'h0e, op_lui   = 6'h0f,
    op_lb      = 6'h20, op_lh     = 6'h21, op_lw    = 6'h23, op_lbu   = 6'h24,
    op_lhu     = 6'h25, op_sb     = 6'h28, op_sh    = 6'h29, op_sw    = 6'h2b
  } opcode_t;

  typedef enum logic [funct_width-1:0] {
    fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03, fn_sllv = 6'h04,
    fn_srlv = 6'h06, fn_srav = 6'h07, fn_jr   = 6'h08, fn_jalr = 6'h09,
    fn_add  = 6'h20, fn_addu = 6'h21, fn_sub  = 6'h22, fn_subu = 6'h23,
    fn_and  = 6'h24, fn_or   = 6'h25, fn_xor  = 6'h26, fn_nor  = 6'h27,
    fn_slt  = 6'h2a, fn_sltu = 6'h2b
  } funct_t;

  // rt field codes under op_regimm
  typedef enum logic [reg_addr_width-1:0] {
    ri_bltz   = 5'h00,
    ri_bgez   = 5'h01,
    ri_bltzal = 5'h10,
    ri_bgezal = 5'h11
  } regimm_t;

endpackage

`default_nettype wire

// File: verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int imm_width = 16;

  typedef enum logic [3:0] {
    alu_none,
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_and,
    alu_nor,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lui
  } alu_op_t;

  typedef enum logic [1:0] {
    mem_none,
    mem_byte,
    mem_half,
    mem_word
  } mem_size_t;

  // one-hot branch class
  localparam int branch_kind_width = 4;
  localparam int branch_eq_bit = 0;
  localparam int branch_ne_bit = 1;
  localparam int branch_sign_bit = 2;
  localparam int branch_jump_bit = 3;

  // bit 1 of the sign condition marks blez and bgtz
  // bit 0 marks the ge and gt forms
  localparam int branch_cond_width = 2;

endpackage

`default_nettype wire

// File: verilog/decode_latch.sv
`default_nettype none

module decode_latch
  import isa_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      if_valid,
  input  word_t     if_instruction,
  input  word_t     if_pc,
  input  logic      ex_allow_in,
  input  logic      ex_write_valid,
  input  reg_addr_t ex_write_register,
  input  reg_addr_t rs,
  input  reg_addr_t rt,
  input  logic      rs_used,
  input  logic      rt_used,
  output logic      allow_in,
  output logic      ex_valid,
  output word_t     instruction,
  output word_t     pc
);

  logic valid;
  logic hazard;
  logic ready;

  // execute will write a register we still have to read
  assign hazard = ex_write_valid && (ex_write_register != '0) &&
                  ((rs_used && ex_write_register == rs) ||
                   (rt_used && ex_write_register == rt));
  assign ready = !hazard;

  assign allow_in = !valid || (ready && ex_allow_in);
  assign ex_valid = valid && ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (allow_in) begin
      valid <= if_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_valid && allow_in) begin
      instruction <= if_instruction;
      pc <= if_pc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`default_nettype none

module instr_decoder
  import isa_pkg::*;
  import decode_pkg::*;
(
  input  word_t                        instruction,
  output reg_addr_t                    rs,
  output reg_addr_t                    rt,
  output logic                         rs_used,
  output logic                         rt_used,
  output logic [imm_width-1:0]         immediate,
  output reg_addr_t                    write_register,
  output logic                         register_write,
  output alu_op_t                      alu_op,
  output logic                         src1_is_shamt,
  output logic                         src1_is_pc,
  output logic                         src2_is_imm,
  output logic                         src2_is_unsigned,
  output logic                         src2_is_8,
  output logic                         mem_write,
  output logic                         is_load,
  output mem_size_t                    mem_size,
  output logic                         mem_unsigned,
  output logic [branch_kind_width-1:0] branch_kind,
  output logic [branch_cond_width-1:0] branch_cond,
  output logic                         target_from_rs
);

  opcode_t opcode;
  funct_t funct;
  reg_addr_t rd;
  logic [shamt_width-1:0] shamt;
  alu_op_t special_op;
  logic shift_by_shamt;
  logic link_dest;
  logic rt_dest;

  function automatic alu_op_t special_alu_op(funct_t f);
    case (f)
      fn_add, fn_addu: return alu_add;
      fn_sub, fn_subu: return alu_sub;
      fn_slt: return alu_slt;
      fn_sltu: return alu_sltu;
      fn_and: return alu_and;
      fn_nor: return alu_nor;
      fn_or: return alu_or;
      fn_xor: return alu_xor;
      fn_sll, fn_sllv: return alu_sll;
      fn_srl, fn_srlv: return alu_srl;
      fn_sra, fn_srav: return alu_sra;
      default: return alu_none;
    endcase
  endfunction

  function automatic mem_size_t access_size(opcode_t op);
    case (op)
      op_lb, op_lbu, op_sb: return mem_byte;
      op_lh, op_lhu, op_sh: return mem_half;
      default: return mem_word;
    endcase
  endfunction

  assign opcode = opcode_t'(instruction[opcode_lsb +: opcode_width]);
  assign funct = funct_t'(instruction[funct_width-1:0]);
  assign rs = instruction[rs_lsb +: reg_addr_width];
  assign rt = instruction[rt_lsb +: reg_addr_width];
  assign rd = instruction[rd_lsb +: reg_addr_width];
  assign shamt = instruction[shamt_lsb +: shamt_width];
  assign immediate = instruction[imm_width-1:0];

  assign special_op = special_alu_op(funct);
  assign shift_by_shamt = funct inside {fn_sll, fn_srl, fn_sra};

  always_comb begin
    alu_op = alu_none;
    rs_used = 1'b0;
    rt_used = 1'b0;
    register_write = 1'b0;
    link_dest = 1'b0;
    rt_dest = 1'b0;
    src1_is_shamt = 1'b0;
    src1_is_pc = 1'b0;
    src2_is_imm = 1'b0;
    src2_is_unsigned = 1'b0;
    src2_is_8 = 1'b0;
    mem_write = 1'b0;
    is_load = 1'b0;
    mem_size = mem_none;
    mem_unsigned = 1'b0;
    branch_kind = '0;
    branch_cond = '0;
    target_from_rs = 1'b0;
    case (opcode)
      op_special: begin
        if (funct == fn_jr || funct == fn_jalr) begin
          // jr also needs rd clear
          if (rt == '0 && shamt == '0 && (funct == fn_jalr || rd == '0)) begin
            rs_used = 1'b1;
            target_from_rs = 1'b1;
            branch_kind[branch_jump_bit] = 1'b1;
            link_dest = (funct == fn_jalr);
          end
        end else if (special_op != alu_none && (shift_by_shamt ? rs == '0 : shamt == '0)) begin
          alu_op = special_op;
          register_write = 1'b1;
          rs_used = !shift_by_shamt;
          rt_used = 1'b1;
          src1_is_shamt = shift_by_shamt;
        end
      end
      op_regimm: begin
        if (rt inside {ri_bltz, ri_bgez, ri_bltzal, ri_bgezal}) begin
          rs_used = 1'b1;
          branch_kind[branch_sign_bit] = 1'b1;
          branch_cond = {1'b0, rt == ri_bgez || rt == ri_bgezal};
          link_dest = (rt == ri_bltzal || rt == ri_bgezal);
        end
      end
      op_j, op_jal: begin
        branch_kind[branch_jump_bit] = 1'b1;
        link_dest = (opcode == op_jal);
      end
      op_beq, op_bne: begin
        rs_used = 1'b1;
        rt_used = 1'b1;
        branch_kind[branch_eq_bit] = (opcode == op_beq);
        branch_kind[branch_ne_bit] = (opcode == op_bne);
      end
      op_blez, op_bgtz: begin
        if (rt == '0) begin
          rs_used = 1'b1;
          branch_kind[branch_sign_bit] = 1'b1;
          branch_cond = {1'b1, opcode == op_bgtz};
        end
      end
      op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
        rs_used = 1'b1;
        src2_is_imm = 1'b1;
        register_write = 1'b1;
        rt_dest = 1'b1;
        src2_is_unsigned = opcode inside {op_andi, op_ori, op_xori};
        case (opcode)
          op_addi, op_addiu: alu_op = alu_add;
          op_slti: alu_op = alu_slt;
          op_sltiu: alu_op = alu_sltu;
          op_andi: alu_op = alu_and;
          op_ori: alu_op = alu_or;
          default: alu_op = alu_xor;
        endcase
      end
      op_lui: begin
        if (rs == '0) begin
          alu_op = alu_lui;
          src2_is_imm = 1'b1;
          register_write = 1'b1;
          rt_dest = 1'b1;
        end
      end
      op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
        alu_op = alu_add;
        rs_used = 1'b1;
        src2_is_imm = 1'b1;
        register_write = 1'b1;
        rt_dest = 1'b1;
        is_load = 1'b1;
        mem_size = access_size(opcode);
        mem_unsigned = opcode inside {op_lbu, op_lhu};
      end
      op_sb, op_sh, op_sw: begin
        alu_op = alu_add;
        rs_used = 1'b1;
        rt_used = 1'b1;
        src2_is_imm = 1'b1;
        mem_write = 1'b1;
        mem_size = access_size(opcode);
      end
      default: begin
      end
    endcase
    // linking forms compute pc + 8 into the link register
    if (link_dest) begin
      alu_op = alu_add;
      register_write = 1'b1;
      src1_is_pc = 1'b1;
      src2_is_8 = 1'b1;
    end
  end

  assign write_register = link_dest ? reg_addr_t'(link_register) : rt_dest ? rt : rd;

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`default_nettype none

module register_file
  import isa_pkg::*;
(
  input  logic      clock,
  input  reg_addr_t read_address_1,
  input  reg_addr_t read_address_2,
  output word_t     read_data_1,
  output word_t     read_data_2,
  input  logic      write_enable,
  input  reg_addr_t write_address,
  input  word_t     write_data
);

  word_t registers [num_regs];

  // register 0 is never written
  always_ff @(posedge clock) begin
    if (write_enable && write_address != '0) begin
      registers[write_address] <= write_data;
    end
  end

  assign read_data_1 = (read_address_1 == '0) ? '0 : registers[read_address_1];
  assign read_data_2 = (read_address_2 == '0) ? '0 : registers[read_address_2];

endmodule

`default_nettype wire

// File: verilog/operand_read.sv
`default_nettype none

module operand_read
  import isa_pkg::*;
(
  input  logic      clock,
  input  reg_addr_t rs,
  input  reg_addr_t rt,
  input  logic      wb_write_enable,
  input  reg_addr_t wb_write_register,
  input  word_t     wb_write_data,
  output word_t     rs_value,
  output word_t     rt_value
);

  word_t rs_array_value;
  word_t rt_array_value;
  logic rs_forward;
  logic rt_forward;

  register_file register_file_i (
    .clock          (clock),
    .read_address_1 (rs),
    .read_address_2 (rt),
    .read_data_1    (rs_array_value),
    .read_data_2    (rt_array_value),
    .write_enable   (wb_write_enable),
    .write_address  (wb_write_register),
    .write_data     (wb_write_data)
  );

  assign rs_forward = wb_write_enable && wb_write_register != '0 && wb_write_register == rs;
  assign rt_forward = wb_write_enable && wb_write_register != '0 && wb_write_register == rt;

  // write-back data wins over the array in the cycle it is written
  assign rs_value = rs_forward ? wb_write_data : rs_array_value;
  assign rt_value = rt_forward ? wb_write_data : rt_array_value;

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
`default_nettype none

module branch_unit
  import isa_pkg::*;
  import decode_pkg::*;
(
  input  logic                         valid,
  input  word_t                        pc,
  input  word_t                        rs_value,
  input  word_t                        rt_value,
  input  logic [imm_width-1:0]         immediate,
  input  logic [jump_index_width-1:0]  jump_index,
  input  logic [branch_kind_width-1:0] branch_kind,
  input  logic [branch_cond_width-1:0] branch_cond,
  input  logic                         target_from_rs,
  output logic                         taken,
  output word_t                        target
);

  word_t pc_plus_4;
  word_t offset;
  logic equal;
  logic negative;
  logic positive;
  logic sign_met;

  assign pc_plus_4 = pc + word_t'(4);
  assign offset = {{(word_width - imm_width - 2){immediate[imm_width-1]}}, immediate, 2'b00};

  assign equal = (rs_value == rt_value);
  assign negative = rs_value[word_width-1];
  assign positive = !negative && (rs_value != '0);

  always_comb begin
    if (branch_cond[1]) begin
      // bgtz / blez
      sign_met = branch_cond[0] ? positive : !positive;
    end else begin
      // bgez / bltz and their linking forms
      sign_met = branch_cond[0] ? !negative : negative;
    end
  end

  assign taken = valid && ((branch_kind[branch_eq_bit] && equal) ||
                           (branch_kind[branch_ne_bit] && !equal) ||
                           (branch_kind[branch_sign_bit] && sign_met) ||
                           branch_kind[branch_jump_bit]);

  assign target = target_from_rs ? rs_value :
                  branch_kind[branch_jump_bit] ?
                    {pc_plus_4[word_width-1 -: 4], jump_index, 2'b00} :
                  pc_plus_4 + offset;

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage
  import isa_pkg::*;
  import decode_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 if_valid,
  input  word_t                if_instruction,
  input  word_t                if_pc,
  input  logic                 ex_allow_in,
  input  logic                 ex_write_valid,
  input  reg_addr_t            ex_write_register,
  input  logic                 wb_write_enable,
  input  reg_addr_t            wb_write_register,
  input  word_t                wb_write_data,
  output logic                 allow_in,
  output logic                 branch_taken,
  output word_t                branch_target,
  output logic                 ex_valid,
  output word_t                ex_pc,
  output word_t                ex_rs_value,
  output word_t                ex_rt_value,
  output logic [imm_width-1:0] ex_immediate,
  output reg_addr_t            ex_dest_register,
  output logic                 ex_register_write,
  output alu_op_t              ex_alu_op,
  output logic                 ex_src1_is_shamt,
  output logic                 ex_src1_is_pc,
  output logic                 ex_src2_is_imm,
  output logic                 ex_src2_is_unsigned,
  output logic                 ex_src2_is_8,
  output logic                 ex_mem_write,
  output logic                 ex_is_load,
  output mem_size_t            ex_mem_size,
  output logic                 ex_mem_unsigned
);

  word_t instruction;
  reg_addr_t rs;
  reg_addr_t rt;
  logic rs_used;
  logic rt_used;
  logic [branch_kind_width-1:0] branch_kind;
  logic [branch_cond_width-1:0] branch_cond;
  logic target_from_rs;

  decode_latch decode_latch_i (
    .clock             (clock),
    .reset             (reset),
    .if_valid          (if_valid),
    .if_instruction    (if_instruction),
    .if_pc             (if_pc),
    .ex_allow_in       (ex_allow_in),
    .ex_write_valid    (ex_write_valid),
    .ex_write_register (ex_write_register),
    .rs                (rs),
    .rt                (rt),
    .rs_used           (rs_used),
    .rt_used           (rt_used),
    .allow_in          (allow_in),
    .ex_valid          (ex_valid),
    .instruction       (instruction),
    .pc                (ex_pc)
  );

  instr_decoder instr_decoder_i (
    .instruction      (instruction),
    .rs               (rs),
    .rt               (rt),
    .rs_used          (rs_used),
    .rt_used          (rt_used),
    .immediate        (ex_immediate),
    .write_register   (ex_dest_register),
    .register_write   (ex_register_write),
    .alu_op           (ex_alu_op),
    .src1_is_shamt    (ex_src1_is_shamt),
    .src1_is_pc       (ex_src1_is_pc),
    .src2_is_imm      (ex_src2_is_imm),
    .src2_is_unsigned (ex_src2_is_unsigned),
    .src2_is_8        (ex_src2_is_8),
    .mem_write        (ex_mem_write),
    .is_load          (ex_is_load),
    .mem_size         (ex_mem_size),
    .mem_unsigned     (ex_mem_unsigned),
    .branch_kind      (branch_kind),
    .branch_cond      (branch_cond),
    .target_from_rs   (target_from_rs)
  );

  operand_read operand_read_i (
    .clock             (clock),
    .rs                (rs),
    .rt                (rt),
    .wb_write_enable   (wb_write_enable),
    .wb_write_register (wb_write_register),
    .wb_write_data     (wb_write_data),
    .rs_value          (ex_rs_value),
    .rt_value          (ex_rt_value)
  );

  // a stalled branch must not redirect fetch
  branch_unit branch_unit_i (
    .valid          (ex_valid),
    .pc             (ex_pc),
    .rs_value       (ex_rs_value),
    .rt_value       (ex_rt_value),
    .immediate      (ex_immediate),
    .jump_index     (instruction[jump_index_width-1:0]),
    .branch_kind    (branch_kind),
    .branch_cond    (branch_cond),
    .target_from_rs (target_from_rs),
    .taken          (branch_taken),
    .target         (branch_target)
  );

endmodule

`default_nettype wire

// File: tb/decode_checker.sv
`default_nettype none

module decode_checker
  import isa_pkg::*;
  import decode_pkg::*;
(
  input wire logic                 clock,
  input wire logic                 reset,
  input wire logic                 if_valid,
  input wire word_t                if_instruction,
  input wire word_t                if_pc,
  input wire logic                 ex_allow_in,
  input wire logic                 ex_write_valid,
  input wire reg_addr_t            ex_write_register,
  input wire logic                 wb_write_enable,
  input wire reg_addr_t            wb_write_register,
  input wire word_t                wb_write_data,
  input wire logic                 allow_in,
  input wire logic                 branch_taken,
  input wire word_t                branch_target,
  input wire logic                 ex_valid,
  input wire word_t                ex_pc,
  input wire word_t                ex_rs_value,
  input wire word_t                ex_rt_value,
  input wire logic [imm_width-1:0] ex_immediate,
  input wire reg_addr_t            ex_dest_register,
  input wire logic                 ex_register_write,
  input wire alu_op_t              ex_alu_op,
  input wire logic                 ex_src1_is_shamt,
  input wire logic                 ex_src1_is_pc,
  input wire logic                 ex_src2_is_imm,
  input wire logic                 ex_src2_is_unsigned,
  input wire logic                 ex_src2_is_8,
  input wire logic                 ex_mem_write,
  input wire logic                 ex_is_load,
  input wire mem_size_t            ex_mem_size,
  input wire logic                 ex_mem_unsigned
);

  timeunit 1ns;
  timeprecision 1ps;

  // cond holds 0 for none, then beq, bne, bltz, bgez, blez and bgtz as 1 to 6
  typedef struct packed {
    logic      rs_used;
    logic      rt_used;
    reg_addr_t dest;
    logic      reg_write;
    alu_op_t   alu;
    logic      src1_shamt;
    logic      src1_pc;
    logic      src2_imm;
    logic      src2_uns;
    logic      src2_8;
    logic      mem_write;
    logic      is_load;
    mem_size_t size;
    logic      mem_uns;
    logic      jump;
    logic      jump_reg;
    logic [2:0] cond;
  } expect_t;

  int check_count = 0;
  int error_count = 0;

  word_t model [num_regs];
  logic  lat_valid;
  word_t lat_instr;
  word_t lat_pc;

  initial model[0] = '0;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic expect_t reference_decode(word_t w);
    expect_t d;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic link;
    logic by_sa;
    alu_op_t a;
    op = w[31:26];
    fn = w[5:0];
    rs = w[25:21];
    rt = w[20:16];
    rd = w[15:11];
    sa = w[10:6];
    link = 1'b0;
    d = '0;
    d.dest = rd;
    case (op)
      6'h00: begin
        if (fn == 6'h08 || fn == 6'h09) begin
          if (rt == 0 && sa == 0 && (fn == 6'h09 || rd == 0)) begin
            d.rs_used = 1'b1;
            d.jump = 1'b1;
            d.jump_reg = 1'b1;
            link = (fn == 6'h09);
          end
        end else begin
          case (fn)
            6'h00, 6'h04: a = alu_sll;
            6'h02, 6'h06: a = alu_srl;
            6'h03, 6'h07: a = alu_sra;
            6'h20, 6'h21: a = alu_add;
            6'h22, 6'h23: a = alu_sub;
            6'h24: a = alu_and;
            6'h25: a = alu_or;
            6'h26: a = alu_xor;
            6'h27: a = alu_nor;
            6'h2a: a = alu_slt;
            6'h2b: a = alu_sltu;
            default: a = alu_none;
          endcase
          by_sa = (fn <= 6'h03);
          if (a != alu_none && (by_sa ? rs == 0 : sa == 0)) begin
            d.alu = a;
            d.reg_write = 1'b1;
            d.rs_used = !by_sa;
            d.rt_used = 1'b1;
            d.src1_shamt = by_sa;
          end
        end
      end
      6'h01: begin
        if (rt == 5'h00 || rt == 5'h01 || rt == 5'h10 || rt == 5'h11) begin
          d.rs_used = 1'b1;
          d.cond = rt[0] ? 3'd4 : 3'd3;
          link = rt[4];
        end
      end
      6'h02, 6'h03: begin
        d.jump = 1'b1;
        link = op[0];
      end
      6'h04, 6'h05: begin
        d.rs_used = 1'b1;
        d.rt_used = 1'b1;
        d.cond = op[0] ? 3'd2 : 3'd1;
      end
      6'h06, 6'h07: begin
        if (rt == 0) begin
          d.rs_used = 1'b1;
          d.cond = op[0] ? 3'd6 : 3'd5;
        end
      end
      6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: begin
        d.rs_used = 1'b1;
        d.src2_imm = 1'b1;
        d.reg_write = 1'b1;
        d.dest = rt;
        d.src2_uns = (op >= 6'h0c);
        case (op)
          6'h0a: d.alu = alu_slt;
          6'h0b: d.alu = alu_sltu;
          6'h0c: d.alu = alu_and;
          6'h0d: d.alu = alu_or;
          6'h0e: d.alu = alu_xor;
          default: d.alu = alu_add;
        endcase
      end
      6'h0f: begin
        if (rs == 0) begin
          d.alu = alu_lui;
          d.src2_imm = 1'b1;
          d.reg_write = 1'b1;
          d.dest = rt;
        end
      end
      6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: begin
        d.alu = alu_add;
        d.rs_used = 1'b1;
        d.src2_imm = 1'b1;
        // bits 1:0 give the access size and bit 3 marks a store
        d.size = (op[1:0] == 2'b00) ? mem_byte : (op[1:0] == 2'b01) ? mem_half : mem_word;
        if (op[3]) begin
          d.rt_used = 1'b1;
          d.mem_write = 1'b1;
        end else begin
          d.reg_write = 1'b1;
          d.dest = rt;
          d.is_load = 1'b1;
          d.mem_uns = op[2];
        end
      end
      default: begin
      end
    endcase
    if (link) begin
      d.alu = alu_add;
      d.reg_write = 1'b1;
      d.src1_pc = 1'b1;
      d.src2_8 = 1'b1;
      d.dest = 5'd31;
    end
    return d;
  endfunction

  function automatic word_t operand_value(reg_addr_t address);
    if (wb_write_enable && wb_write_register != 0 && wb_write_register == address) begin
      return wb_write_data;
    end
    return (address == 0) ? word_t'(0) : model[address];
  endfunction

  function automatic logic condition_met(expect_t d, word_t a, word_t b);
    case (d.cond)
      3'd1: return a == b;
      3'd2: return a != b;
      3'd3: return $signed(a) < 0;
      3'd4: return $signed(a) >= 0;
      3'd5: return $signed(a) <= 0;
      3'd6: return $signed(a) > 0;
      default: return d.jump;
    endcase
  endfunction

  always @(posedge clock) begin
    expect_t d;
    logic hazard;
    logic exp_valid;
    logic exp_allow;
    logic exp_taken;
    word_t rs_val;
    word_t rt_val;
    word_t pc4;
    word_t exp_target;
    if (!reset) begin
      d = reference_decode(lat_instr);
      hazard = ex_write_valid && ex_write_register != 0 &&
               ((d.rs_used && ex_write_register == lat_instr[25:21]) ||
                (d.rt_used && ex_write_register == lat_instr[20:16]));
      exp_valid = lat_valid && !hazard;
      exp_allow = !lat_valid || (!hazard && ex_allow_in);
      rs_val = operand_value(lat_instr[25:21]);
      rt_val = operand_value(lat_instr[20:16]);
      exp_taken = exp_valid && condition_met(d, rs_val, rt_val);
      check("allow_in", exp_allow, allow_in);
      check("ex_valid", exp_valid, ex_valid);
      check("branch_taken", exp_taken, branch_taken);
      if (lat_valid) begin
        check("ex_pc", lat_pc, ex_pc);
        check("ex_immediate", lat_instr[15:0], ex_immediate);
        check("ex_rs_value", rs_val, ex_rs_value);
        check("ex_rt_value", rt_val, ex_rt_value);
        check("ex_register_write", d.reg_write, ex_register_write);
        if (d.reg_write) begin
          check("ex_dest_register", d.dest, ex_dest_register);
        end
        check("ex_alu_op", d.alu, ex_alu_op);
        check("ex_src1_is_shamt", d.src1_shamt, ex_src1_is_shamt);
        check("ex_src1_is_pc", d.src1_pc, ex_src1_is_pc);
        check("ex_src2_is_imm", d.src2_imm, ex_src2_is_imm);
        check("ex_src2_is_unsigned", d.src2_uns, ex_src2_is_unsigned);
        check("ex_src2_is_8", d.src2_8, ex_src2_is_8);
        check("ex_mem_write", d.mem_write, ex_mem_write);
        check("ex_is_load", d.is_load, ex_is_load);
        check("ex_mem_size", d.size, ex_mem_size);
        check("ex_mem_unsigned", d.mem_uns, ex_mem_unsigned);
        pc4 = lat_pc + 32'd4;
        if (d.jump_reg) begin
          exp_target = rs_val;
        end else if (d.jump) begin
          exp_target = {pc4[31:28], lat_instr[25:0], 2'b00};
        end else begin
          exp_target = pc4 + {{14{lat_instr[15]}}, lat_instr[15:0], 2'b00};
        end
        if (exp_taken) begin
          check("branch_target", exp_target, branch_target);
        end
      end
    end
    if (reset) begin
      lat_valid <= 1'b0;
    end else if (!lat_valid || (!hazard && ex_allow_in)) begin
      lat_valid <= if_valid;
      if (if_valid) begin
        lat_instr <= if_instruction;
        lat_pc <= if_pc;
      end
    end
    if (wb_write_enable && wb_write_register != 0) begin
      model[wb_write_register] <= wb_write_data;
    end
  end

endmodule

`default_nettype wire

// File: tb/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb
  import isa_pkg::*;
  import decode_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clock_period = 100;
  localparam int reset_cycles = 5;
  localparam int test_cycles = 2000;
  localparam int total_cycles = reset_cycles + num_regs + test_cycles + 4;

  logic clock;
  logic reset;
  logic if_valid;
  word_t if_instruction;
  word_t if_pc;
  logic ex_allow_in;
  logic ex_write_valid;
  reg_addr_t ex_write_register;
  logic wb_write_enable;
  reg_addr_t wb_write_register;
  word_t wb_write_data;
  logic allow_in;
  logic branch_taken;
  word_t branch_target;
  logic ex_valid;
  word_t ex_pc;
  word_t ex_rs_value;
  word_t ex_rt_value;
  logic [imm_width-1:0] ex_immediate;
  reg_addr_t ex_dest_register;
  logic ex_register_write;
  alu_op_t ex_alu_op;
  logic ex_src1_is_shamt;
  logic ex_src1_is_pc;
  logic ex_src2_is_imm;
  logic ex_src2_is_unsigned;
  logic ex_src2_is_8;
  logic ex_mem_write;
  logic ex_is_load;
  mem_size_t ex_mem_size;
  logic ex_mem_unsigned;

  int seed = 6556;

  // kept primary opcodes and special function codes
  logic [5:0] opcode_table [24] = '{
    6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
    6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
    6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b
  };
  logic [5:0] funct_table [18] = '{
    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h20,
    6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
  };

  decode_stage dut_i (.*);

  decode_checker checker_i (.*);

  always #(clock_period / 2) clock = ~clock;

  // mostly kept encodings with narrow register fields so hazards and forwarding show up
  task automatic random_instruction(output word_t w);
    int pick;
    w = $random(seed);
    pick = $random(seed);
    if (pick[2:0] != 0) begin
      w[31:26] = opcode_table[$unsigned($random(seed)) % 24];
      if (w[31:26] == 6'h00) begin
        w[5:0] = funct_table[$unsigned($random(seed)) % 18];
      end
      if (pick[3]) begin
        w[10:6] = '0;
      end
      if (pick[5:4] == 0) begin
        w[25:21] = '0;
      end
      if (pick[7:6] == 0) begin
        w[20:16] = '0;
      end
      if (pick[9:8] == 0) begin
        w[15:11] = '0;
      end
      if (pick[10]) begin
        w[25:24] = '0;
        w[20:19] = '0;
      end
      if (w[31:26] == 6'h01) begin
        w[20:16] = {pick[11], 3'b000, pick[12]};
      end
    end
  endtask

  initial begin
    word_t w;
    word_t bits;
    clock = 1'b0;
    reset = 1'b1;
    if_valid = 1'b0;
    if_instruction = '0;
    if_pc = '0;
    ex_allow_in = 1'b0;
    ex_write_valid = 1'b0;
    ex_write_register = '0;
    wb_write_enable = 1'b0;
    wb_write_register = '0;
    wb_write_data = '0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int r = 1; r < num_regs; r++) begin
      @(negedge clock);
      wb_write_enable = 1'b1;
      wb_write_register = reg_addr_t'(r);
      wb_write_data = $random(seed);
    end
    @(negedge clock);
    wb_write_enable = 1'b0;
    repeat (test_cycles) begin
      @(negedge clock);
      bits = $random(seed);
      random_instruction(w);
      if_valid = bits[0];
      if_instruction = w;
      if_pc = {$random(seed)} & 32'hffff_fffc;
      ex_allow_in = (bits[2:1] != 2'b00);
      ex_write_valid = bits[3];
      ex_write_register = {2'b00, bits[6:4]};
      wb_write_enable = bits[7];
      wb_write_register = bits[8] ? bits[13:9] : {2'b00, bits[11:9]};
      wb_write_data = $random(seed);
    end
    @(negedge clock);
    if_valid = 1'b0;
    wb_write_enable = 1'b0;
    repeat (2) @(negedge clock);
    $display("checks: %0d, errors: %0d", checker_i.check_count, checker_i.error_count);
    if (checker_i.error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #((total_cycles + 50) * clock_period);
    $display("timeout: the run did not reach its end in the expected time");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/isa_pkg.sv
verilog/decode_pkg.sv
verilog/decode_latch.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/operand_read.sv
verilog/branch_unit.sv
verilog/decode_stage.sv
tb/decode_checker.sv
tb/decode_stage_tb.sv

// File: Makefile
TOP ?= decode_stage_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
